// File: cmd_parser.sv
// ====================
// Command parser: opcode and row decode, payload output register
// ====================
`default_nettype none

module cmd_parser (
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input logic [7:0] in_data,
    output logic pay_valid,
    input logic pay_ready,
    output logic [7:0] pay_data,
    output led_pkg::row_cmd_e pay_cmd,
    output logic [led_pkg::ROW_BITS-1:0] pay_row
);
    import led_pkg::*;

    typedef enum logic [1:0] {
        ST_OPCODE,
        ST_ROW,
        ST_PAYLOAD
    } state_e;

    state_e state;
    logic armed;
    row_cmd_e cur_cmd;
    logic [ROW_BITS-1:0] cur_row;
    logic [COUNT_BITS-1:0] remaining;
    logic in_accept;

    // Header bytes always go through, payload waits for a free slot
    always_comb begin
        case (state)
            ST_PAYLOAD: in_ready = ~pay_valid | pay_ready;
            default: in_ready = armed;
        endcase
    end

    assign in_accept = in_valid & in_ready;

    // ====================
    // Control FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_OPCODE;
            armed <= 1'b0;
            pay_valid <= 1'b0;
            cur_cmd <= WRITE;
            remaining <= '0;
        end else begin
            armed <= 1'b1;
            if (pay_valid && pay_ready) begin
                pay_valid <= 1'b0;
            end
            if (in_accept) begin
                case (state)
                    ST_OPCODE: begin
                        // Anything else is dropped here
                        if (in_data == OP_WRITE_ROW) begin
                            cur_cmd <= WRITE;
                            state <= ST_ROW;
                        end else if (in_data == OP_FILL_ROW) begin
                            cur_cmd <= FILL;
                            state <= ST_ROW;
                        end
                    end
                    ST_ROW: begin
                        if (cur_cmd == FILL) begin
                            remaining <= '0;
                        end else begin
                            remaining <= COUNT_BITS'(ROW_BYTES - 1);
                        end
                        state <= ST_PAYLOAD;
                    end
                    ST_PAYLOAD: begin
                        pay_valid <= 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == '0) begin
                            state <= ST_OPCODE;
                        end
                    end
                    default: state <= ST_OPCODE;
                endcase
            end
        end
    end

    // ====================
    // Row and payload slot
    // ====================
    always_ff @(posedge clk) begin
        if (in_accept && state == ST_ROW) begin
            cur_row <= in_data[ROW_BITS-1:0];
        end
        // Command and row ride with each byte so they stay put under stall
        if (in_accept && state == ST_PAYLOAD) begin
            pay_data <= in_data;
            pay_cmd <= cur_cmd;
            pay_row <= cur_row;
        end
    end

endmodule

`default_nettype wire

// File: framebuffer.sv
// ====================
// Frame buffer byte RAM, one write port and a registered read port
// ====================
`default_nettype none

module framebuffer (
    input logic clk,
    pixel_write_if.sink wr,
    input logic [led_pkg::ROW_BITS-1:0] rd_row,
    input logic [led_pkg::COLUMN_BITS-1:0] rd_column,
    input logic [led_pkg::PIXEL_BITS-1:0] rd_pixel,
    output logic [7:0] rd_data
);
    import led_pkg::*;

    logic [7:0] mem [0:NUM_ROWS*ROW_BYTES-1];
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    // row * 192 + column * 3 + color index
    function automatic logic [ADDR_BITS-1:0] byte_addr(
        input logic [ROW_BITS-1:0] row,
        input logic [COLUMN_BITS-1:0] column,
        input logic [PIXEL_BITS-1:0] pixel
    );
        return ADDR_BITS'(row * ROW_BYTES + column * BYTES_PER_PIXEL + pixel);
    endfunction

    assign wr_addr = byte_addr(wr.row, wr.column, wr.pixel);
    assign rd_addr = byte_addr(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: led_frame_loader.f
led_pkg.sv
pixel_write_if.sv
cmd_parser.sv
row_writer.sv
framebuffer.sv
led_frame_loader.sv
led_frame_loader_properties.sv
tb_led_frame_loader.sv

// File: led_frame_loader.sv
// ====================
// LED frame loader top: parser, row writer and frame buffer
// ====================
`default_nettype none

module led_frame_loader (
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input logic [7:0] in_data,
    input logic [led_pkg::ROW_BITS-1:0] rd_row,
    input logic [led_pkg::COLUMN_BITS-1:0] rd_column,
    input logic [led_pkg::PIXEL_BITS-1:0] rd_pixel,
    output logic [7:0] rd_data,
    output logic row_done
);
    import led_pkg::*;

    logic pay_valid;
    logic pay_ready;
    logic [7:0] pay_data;
    row_cmd_e pay_cmd;
    logic [ROW_BITS-1:0] pay_row;

    pixel_write_if pixel_wr ();

    cmd_parser u_cmd_parser (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .pay_valid(pay_valid),
        .pay_ready(pay_ready),
        .pay_data(pay_data),
        .pay_cmd(pay_cmd),
        .pay_row(pay_row)
    );

    row_writer u_row_writer (
        .clk(clk),
        .reset(reset),
        .pay_valid(pay_valid),
        .pay_ready(pay_ready),
        .pay_data(pay_data),
        .pay_cmd(pay_cmd),
        .pay_row(pay_row),
        .wr(pixel_wr.source),
        .row_done(row_done)
    );

    framebuffer u_framebuffer (
        .clk(clk),
        .wr(pixel_wr.sink),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: led_frame_loader_properties.sv
// ====================
// Row writer assertions and their bind into row_writer
// ====================
`default_nettype none

module row_writer_properties (
    input logic clk,
    input logic reset,
    input logic pay_valid,
    input logic pay_ready,
    input logic row_done,
    input logic write_enable,
    input logic [led_pkg::COLUMN_BITS-1:0] column,
    input logic [led_pkg::PIXEL_BITS-1:0] pixel
);
    timeunit 1ns;
    timeprecision 100ps;

    // Write strobe stays low through a held reset
    write_idle_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !write_enable
    ) else $error("write_enable high while reset is held");

    // Row done only marks the final write of a row
    row_done_on_last_write: assert property (
        @(posedge clk) disable iff (reset)
        row_done |-> write_enable && column == '0 && pixel == '0
    ) else $error("row_done high away from the column 0, color 0 write");

    // A write with no byte taken the cycle before is a fill repeat,
    // and the payload input must have been stalled then
    fill_stalls_payload: assert property (
        @(posedge clk) disable iff (reset)
        write_enable && !$past(pay_valid && pay_ready) |-> !$past(pay_ready)
    ) else $error("pay_ready high during a fill burst");

endmodule

bind row_writer row_writer_properties u_properties (
    .clk(clk),
    .reset(reset),
    .pay_valid(pay_valid),
    .pay_ready(pay_ready),
    .row_done(row_done),
    .write_enable(wr.write_enable),
    .column(wr.column),
    .pixel(wr.pixel)
);

`default_nettype wire

// File: led_pkg.sv
// ====================
// Panel geometry, address widths, opcodes and payload command type
// ====================
`default_nettype none

package led_pkg;

    // ====================
    // Panel geometry
    // ====================
    localparam int NUM_ROWS = 32;
    localparam int NUM_COLUMNS = 64;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int ROW_BYTES = NUM_COLUMNS * BYTES_PER_PIXEL;

    // ====================
    // Address fields
    // ====================
    localparam int ROW_BITS = $clog2(NUM_ROWS);
    localparam int COLUMN_BITS = $clog2(NUM_COLUMNS);
    localparam int PIXEL_BITS = $clog2(BYTES_PER_PIXEL);

    // Flat byte address into the whole frame, 6144 bytes
    localparam int ADDR_BITS = $clog2(NUM_ROWS * ROW_BYTES);

    // Payload byte counter in the parser
    localparam int COUNT_BITS = $clog2(ROW_BYTES);

    // ====================
    // Command stream
    // ====================
    localparam logic [7:0] OP_WRITE_ROW = 8'h01;
    localparam logic [7:0] OP_FILL_ROW = 8'h02;

    // Command that a payload byte belongs to
    typedef enum logic {
        WRITE = 1'b0,
        FILL = 1'b1
    } row_cmd_e;

endpackage

`default_nettype wire

// File: pixel_write_if.sv
// ====================
// Single byte write from the row writer into the frame buffer
// ====================
`default_nettype none

interface pixel_write_if;
    import led_pkg::*;

    logic write_enable;
    logic [ROW_BITS-1:0] row;
    logic [COLUMN_BITS-1:0] column;
    // Color byte index within the pixel
    logic [PIXEL_BITS-1:0] pixel;
    logic [7:0] data;

    // No back-pressure, the sink takes one write per cycle
    modport source (
        output write_enable,
        output row,
        output column,
        output pixel,
        output data
    );

    modport sink (
        input write_enable,
        input row,
        input column,
        input pixel,
        input data
    );

endinterface

`default_nettype wire

// File: row_writer.sv
// ====================
// Row writer: payload bytes to addressed writes, descending counters
// ====================
`default_nettype none

module row_writer (
    input logic clk,
    input logic reset,
    input logic pay_valid,
    output logic pay_ready,
    input logic [7:0] pay_data,
    input led_pkg::row_cmd_e pay_cmd,
    input logic [led_pkg::ROW_BITS-1:0] pay_row,
    pixel_write_if.source wr,
    output logic row_done
);
    import led_pkg::*;

    logic fill_active;
    logic [COLUMN_BITS-1:0] column_cnt;
    logic [PIXEL_BITS-1:0] pixel_cnt;
    logic pay_accept;
    logic issue;
    logic last_write;

    // Input stalls for the whole fill burst
    assign pay_ready = ~fill_active;
    assign pay_accept = pay_valid & pay_ready;

    // A write goes out for every accepted byte, and every cycle of a fill
    // until the final write has been shown
    assign issue = pay_accept | (fill_active & ~row_done);
    assign last_write = (column_cnt == '0) && (pixel_cnt == '0);

    // ====================
    // Counters and control
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_active <= 1'b0;
            row_done <= 1'b0;
            wr.write_enable <= 1'b0;
            column_cnt <= COLUMN_BITS'(NUM_COLUMNS - 1);
            pixel_cnt <= PIXEL_BITS'(BYTES_PER_PIXEL - 1);
        end else begin
            wr.write_enable <= issue;
            row_done <= issue & last_write;

            if (issue) begin
                // Color byte counts 2..0, then next column down
                if (pixel_cnt == '0) begin
                    pixel_cnt <= PIXEL_BITS'(BYTES_PER_PIXEL - 1);
                    if (column_cnt == '0) begin
                        column_cnt <= COLUMN_BITS'(NUM_COLUMNS - 1);
                    end else begin
                        column_cnt <= column_cnt - 1'b1;
                    end
                end else begin
                    pixel_cnt <= pixel_cnt - 1'b1;
                end
            end

            if (pay_accept && pay_cmd == FILL) begin
                fill_active <= 1'b1;
            end else if (fill_active && row_done) begin
                // Last fill write was on the bus last cycle
                fill_active <= 1'b0;
            end
        end
    end

    // ====================
    // Write payload
    // ====================
    always_ff @(posedge clk) begin
        if (issue) begin
            wr.column <= column_cnt;
            wr.pixel <= pixel_cnt;
        end
        // Data and row hold during a fill, repeating the fill byte
        if (pay_accept) begin
            wr.data <= pay_data;
            wr.row <= pay_row;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the LED frame loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

echo "Building with Verilator"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_led_frame_loader -f led_frame_loader.f \
    -o tb_led_frame_loader > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $build_status"
    exit 1
fi

echo "Running simulation"
./obj_dir/tb_led_frame_loader > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -q 'All tests passed!' sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: tb_led_frame_loader.sv
// ====================
// Directed testbench for the LED frame loader
// ====================
`default_nettype none

module tb_led_frame_loader;
    timeunit 1ns;
    timeprecision 100ps;

    import led_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic [7:0] in_data;
    logic [ROW_BITS-1:0] rd_row;
    logic [COLUMN_BITS-1:0] rd_column;
    logic [PIXEL_BITS-1:0] rd_pixel;
    logic [7:0] rd_data;
    logic row_done;

    logic [31:0] lfsr_state;
    int row_done_count;
    // Expected frame, only rows that were written get compared
    logic [7:0] model [0:NUM_ROWS*ROW_BYTES-1];

    led_frame_loader dut_i (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data),
        .row_done(row_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pulse counter, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            row_done_count <= 0;
        end else if (row_done === 1'b1) begin
            row_done_count <= row_done_count + 1;
        end
    end

    // ====================
    // Helpers
    // ====================
    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            value[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic int frame_addr(input int row, input int column, input int pixel);
        return row * ROW_BYTES + column * BYTES_PER_PIXEL + pixel;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected 0x%0h, got 0x%0h",
                                name, expected, actual));
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the transfer edge
    task automatic send_byte(input logic [7:0] value);
        int cycles;
        cycles = 0;
        in_valid = 1'b1;
        in_data = value;
        while (!in_ready) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for in_ready to accept a byte");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_row_done(input int target);
        int cycles;
        cycles = 0;
        while (row_done_count < target) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for row_done");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic read_byte(input int row, input int column, input int pixel,
                             output logic [7:0] value);
        rd_row = ROW_BITS'(row);
        rd_column = COLUMN_BITS'(column);
        rd_pixel = PIXEL_BITS'(pixel);
        @(posedge clk);
        #1;
        value = rd_data;
    endtask

    task automatic compare_row(input int row);
        logic [7:0] value;
        for (int col = 0; col < NUM_COLUMNS; col++) begin
            for (int pix = 0; pix < BYTES_PER_PIXEL; pix++) begin
                read_byte(row, col, pix, value);
                check_equal($sformatf("rd_data row %0d column %0d pixel %0d", row, col, pix),
                            32'(model[frame_addr(row, col, pix)]), 32'(value));
            end
        end
    endtask

    task automatic write_row_command(input int row);
        logic [7:0] value;
        int column;
        int pixel;
        send_byte(OP_WRITE_ROW);
        send_byte(8'(row));
        for (int k = 0; k < ROW_BYTES; k++) begin
            random_byte(value);
            // Payload runs from column 63 down, color byte 2 first
            column = NUM_COLUMNS - 1 - k / BYTES_PER_PIXEL;
            pixel = BYTES_PER_PIXEL - 1 - k % BYTES_PER_PIXEL;
            model[frame_addr(row, column, pixel)] = value;
            send_byte(value);
        end
    endtask

    task automatic fill_row_command(input int row, input logic [7:0] value);
        send_byte(OP_FILL_ROW);
        send_byte(8'(row));
        send_byte(value);
        for (int i = 0; i < ROW_BYTES; i++) begin
            model[row * ROW_BYTES + i] = value;
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic after_reset_idle();
        int cycles;
        check_equal("in_ready", 0, 32'(in_ready));
        cycles = 0;
        while (!in_ready) begin
            if (cycles >= 2) begin
                abort_run("in_ready did not rise within 2 cycles of reset release");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        repeat (8) begin
            check_equal("row_done", 0, 32'(row_done));
            @(posedge clk);
            #1;
        end
        check_equal("row_done pulse count", 0, row_done_count);
    endtask

    task automatic write_row_readback();
        int start;
        start = row_done_count;
        write_row_command(5);
        wait_row_done(start + 1);
        repeat (4) @(posedge clk);
        #1;
        check_equal("row_done pulse count", start + 1, row_done_count);
        compare_row(5);
    endtask

    task automatic fill_row_readback();
        int start;
        start = row_done_count;
        fill_row_command(31, 8'hA5);
        wait_row_done(start + 1);
        compare_row(31);
        compare_row(5);
    endtask

    task automatic unknown_opcode_dropped();
        int start;
        start = row_done_count;
        send_byte(8'h7E);
        write_row_command(0);
        wait_row_done(start + 1);
        compare_row(0);
    endtask

    // The write payload queues up behind the fill burst
    task automatic fill_then_write_back_to_back();
        int start;
        start = row_done_count;
        fill_row_command(12, 8'h3C);
        write_row_command(20);
        wait_row_done(start + 2);
        repeat (4) @(posedge clk);
        #1;
        check_equal("row_done pulse count", start + 2, row_done_count);
        compare_row(12);
        compare_row(20);
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        lfsr_state = 32'h61ba;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        after_reset_idle();
        write_row_readback();
        fill_row_readback();
        unknown_opcode_dropped();
        fill_then_write_back_to_back();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
